// File: verif/gameStim.txt
# left right hold expectedPaddleX
# hold counts clock cycles, a multiple of the 8-cycle move interval
0 0 16 80
0 1 40 85
1 0 80 75
1 1 32 75
1 0 640 0
1 0 16 0
0 1 1280 156
0 1 24 156
1 1 16 156
1 0 24 153
0 0 40 153

// File: sources.f
rtl/coinGamePkg.sv
rtl/tickGen.sv
rtl/coinDropper.sv
rtl/paddleMover.sv
rtl/scoreKeeper.sv
rtl/pixelWriter.sv
rtl/coinGame.sv
verif/coinGameChk.sv
verif/coinGameTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = coinGameTb
FILELIST = sources.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/coinGameTb.sv
// ------------------------------------------------
// Coin game testbench
// Stim file buttons, cycle model of the core, checks
// ------------------------------------------------
`timescale 1ns/1ps

module coinGameTb;

	logic clk = 1'b0;
	logic resetn, left, right, plot;
	logic [coinGamePkg::xWidth-1:0] pixelX, paddleX, coinX;
	logic [coinGamePkg::yWidth-1:0] pixelY, coinY;
	coinGamePkg::colourT pixelColour;
	logic [7:0] score;

	int stimLeft[$], stimRight[$], stimHold[$], stimExpect[$]; // One entry per stim line
	int mPaddle, mCoinX, mCoinY, mScore, mCycle; // Reference model state
	bit mLanded, mFalling;
	bit modelValid = 1'b0; // Set by first clock edge
	int candidate, catchOffset;
	int catchCount = 0; // Landings with the coin over the paddle
	int drawnCoinX = 0; // Coin pixel the writer last drew
	int drawnCoinY = 0;
	int expectDraw = 0; // After an erase, 1 coin draw, 2 paddle draw
	int valueErrors = 0, streamErrors = 0;
	int landedCount = 0, cycleCount = 0;
	int cycleLimit = 2000; // Plus every hold length
	int fd, leftVal, rightVal, holdVal, expectVal;
	string line;

	coinGame dut (.*);

	always #20 clk = ~clk; // 40 ns period

	// Mirror a width-bit value end for end
	function automatic int reverseBits(input int value, input int width);
		int result;
		result = 0;
		for (int i = 0; i < width; i++)
			if (value[i])
				result |= 1 << (width - 1 - i);
		return result;
	endfunction

	task automatic compareValue(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			valueErrors++;
			$display("ERR %s expected %0d actual %0d at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic streamFail(input string what);
		streamErrors++;
		$display("Pixel stream error at %0t: %s", $time, what);
	endtask

	// Walk the paddle under the falling coin
	task automatic chaseCoin();
		int target;
		target = mCoinX - 2; // Coin lands mid-paddle
		if (target < 0)
			target = 0;
		else if (target > coinGamePkg::paddleMaxX)
			target = coinGamePkg::paddleMaxX;
		left = mPaddle > target;
		right = mPaddle < target;
	endtask

	// Reference model, one step per rising edge
	always @(posedge clk)
	begin
		cycleCount++;
		if (!resetn)
		begin
			mPaddle = coinGamePkg::paddleStartX;
			mCoinX = 0;
			mCoinY = 0;
			mScore = 0;
			mLanded = 1'b0;
			mFalling = 1'b0;
			mCycle = 0; // Tick phases count from release
			modelValid = 1'b1;
		end
		else
		begin
			// Random counter is the seed plus cycles since reset
			candidate = reverseBits((coinGamePkg::randomSeed + mCycle) % 512, 9)
				^ reverseBits(mPaddle, 8);
			catchOffset = mCoinX - mPaddle;
			if (mLanded && catchOffset >= 0 && catchOffset < coinGamePkg::paddleWidth)
			begin
				mScore = (mScore + 1) % 256; // Catch at landing
				catchCount++;
			end
			mLanded = 1'b0;
			if (!mFalling && candidate < coinGamePkg::screenWidth)
			begin
				mCoinX = candidate; // New coin at top
				mCoinY = 0;
				mFalling = 1'b1;
			end
			else if (mFalling
				&& mCycle % coinGamePkg::dropInterval == coinGamePkg::dropInterval - 1)
			begin
				if (mCoinY == coinGamePkg::coinLastRow)
				begin
					mLanded = 1'b1;
					mFalling = 1'b0;
				end
				else
					mCoinY++;
			end
			if (mCycle % coinGamePkg::moveInterval == coinGamePkg::moveInterval - 1)
			begin
				if (left && !right && mPaddle > 0)
					mPaddle--;
				else if (right && !left && mPaddle < coinGamePkg::paddleMaxX)
					mPaddle++;
			end
			mCycle++;
		end
	end

	initial
	begin
		wait (cycleCount > cycleLimit);
		$display("Timeout: run reached %0d cycles before six landings and a catch", cycleLimit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// Outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (!resetn && plot)
			streamFail("plot raised during reset");
		if (modelValid)
		begin
			compareValue("paddleX", mPaddle, paddleX);
			compareValue("coinX", mCoinX, coinX);
			compareValue("coinY", mCoinY, coinY);
			compareValue("landed", mLanded, dut.landed);
			compareValue("score", mScore, score);
		end
		if (dut.landed)
			landedCount++;
		if (resetn && expectDraw != 0)
		begin
			if (!plot || pixelColour != coinGamePkg::colourWhite)
				streamFail("erase not followed by a white draw");
			else if (expectDraw == 1)
			begin
				compareValue("coin draw x", mCoinX, pixelX);
				compareValue("coin draw y", mCoinY, pixelY);
				drawnCoinX = mCoinX;
				drawnCoinY = mCoinY;
			end
			else
				compareValue("paddle draw y", coinGamePkg::paddleRow, pixelY);
			expectDraw = 0;
		end
		else if (resetn && plot)
		begin
			if (pixelColour != coinGamePkg::colourBlack)
				streamFail("white write with no erase before it");
			else if (pixelX == drawnCoinX && pixelY == drawnCoinY)
				expectDraw = 1; // Old coin pixel erased
			else if (pixelY == coinGamePkg::paddleRow)
				expectDraw = 2; // Trailing paddle column
			else
				streamFail("black write at neither the old coin nor the paddle row");
		end
	end

	initial
	begin
		resetn = 1'b0;
		left = 1'b0;
		right = 1'b0;
		fd = $fopen("verif/gameStim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open verif/gameStim.txt for reading");
			$display("Simulation finished: FAIL");
			$finish;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				// Lines starting with # are the column legend
				if (line.len() > 0 && line[0] != "#"
					&& $sscanf(line, "%d %d %d %d", leftVal, rightVal, holdVal, expectVal) == 4)
				begin
					stimLeft.push_back(leftVal);
					stimRight.push_back(rightVal);
					stimHold.push_back(holdVal);
					stimExpect.push_back(expectVal);
					cycleLimit += holdVal;
				end
			end
			$fclose(fd);
			repeat (5) @(posedge clk);
			#2;
			compareValue("reset plot", 0, plot);
			compareValue("reset score", 0, score);
			compareValue("reset paddleX", coinGamePkg::paddleStartX, paddleX);
			compareValue("reset coinY", 0, coinY);
			resetn = 1'b1; // Cycle 0 of both tick phases
			for (int i = 0; i < stimHold.size(); i++)
			begin
				left = stimLeft[i] != 0;
				right = stimRight[i] != 0;
				repeat (stimHold[i]) @(posedge clk);
				#2;
				compareValue($sformatf("paddle vs model, line %0d", i), mPaddle, paddleX);
				compareValue($sformatf("paddle vs file, line %0d", i), stimExpect[i], paddleX);
			end
			// Chase coins until one is caught so the score moves
			while (landedCount < 6 || catchCount == 0)
			begin
				chaseCoin();
				@(posedge clk);
				#2;
			end
			@(posedge clk); // Last score compare runs on the negedge before this
			#2;
			$display("Checks done: %0d value errors, %0d pixel stream errors",
				valueErrors, streamErrors);
			if (valueErrors == 0 && streamErrors == 0)
				$display("Simulation finished: PASS");
			else
				$display("Simulation finished: FAIL");
			$finish;
		end
	end

endmodule

// File: verif/coinGameChk.sv
// ------------------------------------------------
// Bound checks on the coin game core
// Pixel range, coin and paddle bounds, landed pulse
// ------------------------------------------------
`timescale 1ns/1ps

module coinGameChk
(
	input logic clk,
	input logic resetn,
	input logic plot,
	input logic [coinGamePkg::xWidth-1:0] pixelX,
	input logic [coinGamePkg::yWidth-1:0] pixelY,
	input logic [coinGamePkg::xWidth-1:0] coinX,
	input logic [coinGamePkg::xWidth-1:0] paddleX,
	input logic landed
);

	plotOnScreen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pixelX < coinGamePkg::xWidth'(coinGamePkg::screenWidth))
			&& (pixelY < coinGamePkg::yWidth'(coinGamePkg::screenHeight)))
		else $error("Plot off screen at x=%0d y=%0d", pixelX, pixelY);

	coinOnScreen: assert property (@(posedge clk) disable iff (!resetn)
		coinX < coinGamePkg::xWidth'(coinGamePkg::screenWidth))
		else $error("Coin column %0d off screen", coinX);

	paddleInBounds: assert property (@(posedge clk) disable iff (!resetn)
		paddleX <= coinGamePkg::xWidth'(coinGamePkg::paddleMaxX))
		else $error("Paddle column %0d past right limit", paddleX);

	// Landing is a single-cycle pulse
	landedPulse: assert property (@(posedge clk) disable iff (!resetn)
		landed |=> !landed)
		else $error("landed held for more than one cycle");

endmodule

bind coinGame coinGameChk chk
(
	.clk(clk),
	.resetn(resetn),
	.plot(plot),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.coinX(coinX),
	.paddleX(paddleX),
	.landed(landed)
);

// File: rtl/coinGame.sv
// ------------------------------------------------
// Coin-catching game core, top level
// Emits plot commands and game status
// ------------------------------------------------
`timescale 1ns/1ps

module coinGame
(
	input logic clk,
	input logic resetn,
	input logic left,
	input logic right,
	output logic [coinGamePkg::xWidth-1:0] pixelX,
	output logic [coinGamePkg::yWidth-1:0] pixelY,
	output coinGamePkg::colourT pixelColour,
	output logic plot,
	output logic [coinGamePkg::xWidth-1:0] paddleX,
	output logic [coinGamePkg::xWidth-1:0] coinX,
	output logic [coinGamePkg::yWidth-1:0] coinY,
	output logic [7:0] score
);

	logic dropStrobe; // Coin falls one row
	logic moveStrobe; // Paddle may step
	logic landed; // Coin reached bottom

	tickGen #(.interval(coinGamePkg::dropInterval)) dropTick
	(
		.clk(clk),
		.resetn(resetn),
		.tick(dropStrobe)
	);

	tickGen #(.interval(coinGamePkg::moveInterval)) moveTick
	(
		.clk(clk),
		.resetn(resetn),
		.tick(moveStrobe)
	);

	coinDropper coinDropper
	(
		.clk(clk),
		.resetn(resetn),
		.dropTick(dropStrobe),
		.paddleX(paddleX), // Seeds column pick
		.coinX(coinX),
		.coinY(coinY),
		.landed(landed)
	);

	paddleMover paddleMover
	(
		.clk(clk),
		.resetn(resetn),
		.moveTick(moveStrobe),
		.left(left),
		.right(right),
		.paddleX(paddleX)
	);

	scoreKeeper scoreKeeper
	(
		.clk(clk),
		.resetn(resetn),
		.landed(landed),
		.coinX(coinX),
		.paddleX(paddleX),
		.score(score)
	);

	pixelWriter pixelWriter
	(
		.clk(clk),
		.resetn(resetn),
		.coinX(coinX),
		.coinY(coinY),
		.paddleX(paddleX),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.plot(plot)
	);

endmodule

// File: rtl/pixelWriter.sv
// ------------------------------------------------
// Pixel writer, erase/draw pairs for coin and paddle
// Coin updates go ahead of paddle updates
// ------------------------------------------------
`timescale 1ns/1ps

module pixelWriter
(
	input logic clk,
	input logic resetn,
	input logic [coinGamePkg::xWidth-1:0] coinX,
	input logic [coinGamePkg::yWidth-1:0] coinY,
	input logic [coinGamePkg::xWidth-1:0] paddleX,
	output logic [coinGamePkg::xWidth-1:0] pixelX,
	output logic [coinGamePkg::yWidth-1:0] pixelY,
	output coinGamePkg::colourT pixelColour,
	output logic plot
);

	coinGamePkg::writeStateT state;
	logic [coinGamePkg::xWidth-1:0] lastCoinX; // Coin pixel on screen
	logic [coinGamePkg::yWidth-1:0] lastCoinY;
	logic [coinGamePkg::xWidth-1:0] lastPaddleX; // Paddle on screen
	logic movedRight; // Direction of paddle step being drawn
	logic coinPending;
	logic paddlePending;
	logic [coinGamePkg::xWidth-1:0] paddleEdge; // Right-hand paddle column

	assign coinPending = (coinX != lastCoinX) || (coinY != lastCoinY);
	assign paddlePending = paddleX != lastPaddleX;
	assign paddleEdge = lastPaddleX + coinGamePkg::xWidth'(coinGamePkg::paddleWidth - 1);

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= coinGamePkg::writeIdle;
			lastCoinX <= '0; // Matches coin reset position
			lastCoinY <= '0;
			lastPaddleX <= coinGamePkg::xWidth'(coinGamePkg::paddleStartX);
		end
		else
		begin
			case (state)
				coinGamePkg::writeIdle:
				begin
					if (coinPending)
						state <= coinGamePkg::writeCoinErase;
					else if (paddlePending)
						state <= coinGamePkg::writePaddleErase;
				end
				coinGamePkg::writeCoinErase: state <= coinGamePkg::writeCoinDraw;
				coinGamePkg::writeCoinDraw:
				begin
					lastCoinX <= coinX; // Drawn position becomes the old one
					lastCoinY <= coinY;
					if (paddlePending)
						state <= coinGamePkg::writePaddleErase;
					else
						state <= coinGamePkg::writeIdle;
				end
				coinGamePkg::writePaddleErase:
				begin
					lastPaddleX <= paddleX; // Freeze target for the draw
					state <= coinGamePkg::writePaddleDraw;
				end
				coinGamePkg::writePaddleDraw:
				begin
					if (coinPending)
						state <= coinGamePkg::writeCoinErase;
					else if (paddlePending) // Paddle moved again meanwhile
						state <= coinGamePkg::writePaddleErase;
					else
						state <= coinGamePkg::writeIdle;
				end
				default: state <= coinGamePkg::writeIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == coinGamePkg::writePaddleErase)
			movedRight <= paddleX > lastPaddleX;
	end

	always_comb
	begin
		pixelX = lastCoinX; // Default is the coin erase
		pixelY = lastCoinY;
		pixelColour = coinGamePkg::colourBlack;
		plot = 1'b1;
		case (state)
			coinGamePkg::writeIdle: plot = 1'b0;
			coinGamePkg::writeCoinDraw:
			begin
				pixelX = coinX;
				pixelY = coinY;
				pixelColour = coinGamePkg::colourWhite;
			end
			coinGamePkg::writePaddleErase:
			begin
				// Trailing column of the old paddle
				pixelX = (paddleX > lastPaddleX) ? lastPaddleX : paddleEdge;
				pixelY = coinGamePkg::yWidth'(coinGamePkg::paddleRow);
			end
			coinGamePkg::writePaddleDraw:
			begin
				pixelX = movedRight ? paddleEdge : lastPaddleX; // Leading column
				pixelY = coinGamePkg::yWidth'(coinGamePkg::paddleRow);
				pixelColour = coinGamePkg::colourWhite;
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/scoreKeeper.sv
// ------------------------------------------------
// Score counter, catch test on each landing
// ------------------------------------------------
`timescale 1ns/1ps

module scoreKeeper
(
	input logic clk,
	input logic resetn,
	input logic landed,
	input logic [coinGamePkg::xWidth-1:0] coinX,
	input logic [coinGamePkg::xWidth-1:0] paddleX,
	output logic [7:0] score
);

	logic [coinGamePkg::xWidth-1:0] offset; // Coin column relative to paddle
	logic caught; // Coin over paddle

	assign offset = coinX - paddleX;
	assign caught = (coinX >= paddleX)
		&& (offset < coinGamePkg::xWidth'(coinGamePkg::paddleWidth));

	always_ff @(posedge clk)
	begin
		if (!resetn)
			score <= '0;
		else if (landed && caught)
			score <= score + 8'd1; // Wraps past 255
	end

endmodule

// File: rtl/paddleMover.sv
// ------------------------------------------------
// Paddle position, one column per move tick
// ------------------------------------------------
`timescale 1ns/1ps

module paddleMover
(
	input logic clk,
	input logic resetn,
	input logic moveTick,
	input logic left,
	input logic right,
	output logic [coinGamePkg::xWidth-1:0] paddleX
);

	logic goLeft; // Left move allowed
	logic goRight; // Right move allowed

	// Both buttons cancel out
	assign goLeft = left && !right && (paddleX != '0);
	assign goRight = right && !left
		&& (paddleX < coinGamePkg::xWidth'(coinGamePkg::paddleMaxX));

	always_ff @(posedge clk)
	begin
		if (!resetn)
			paddleX <= coinGamePkg::xWidth'(coinGamePkg::paddleStartX);
		else if (moveTick)
		begin
			if (goLeft)
				paddleX <= paddleX - 1'b1;
			else if (goRight)
				paddleX <= paddleX + 1'b1;
		end
	end

endmodule

// File: rtl/coinDropper.sv
// ------------------------------------------------
// Coin source, random column and falling FSM
// ------------------------------------------------
`timescale 1ns/1ps

module coinDropper
(
	input logic clk,
	input logic resetn,
	input logic dropTick,
	input logic [coinGamePkg::xWidth-1:0] paddleX,
	output logic [coinGamePkg::xWidth-1:0] coinX,
	output logic [coinGamePkg::yWidth-1:0] coinY,
	output logic landed
);

	coinGamePkg::coinStateT state;
	logic [8:0] randCount; // Free-running, never stops
	logic [8:0] revCount; // Bit-reversed counter
	logic [coinGamePkg::xWidth-1:0] revPaddle; // Bit-reversed paddle column
	logic [8:0] candidate; // Column on offer this cycle
	logic candidateOk; // Candidate is on screen
	logic atBottom; // Coin on its last row

	// Reversal puts fast-toggling bits on top
	assign revCount = {<<{randCount}};
	assign revPaddle = {<<{paddleX}};
	assign candidate = revCount ^ 9'(revPaddle); // Paddle stirs the pick
	assign candidateOk = candidate < 9'(coinGamePkg::screenWidth);
	assign atBottom = coinY == coinGamePkg::yWidth'(coinGamePkg::coinLastRow);

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= coinGamePkg::coinPick;
			randCount <= 9'(coinGamePkg::randomSeed);
			coinX <= '0;
			coinY <= '0;
			landed <= 1'b0;
		end
		else
		begin
			randCount <= randCount + 9'd1;
			landed <= 1'b0; // Single-cycle pulse
			case (state)
				coinGamePkg::coinPick:
				begin
					if (candidateOk) // Off-screen picks are skipped
					begin
						coinX <= candidate[coinGamePkg::xWidth-1:0];
						coinY <= '0; // Restart at top
						state <= coinGamePkg::coinFall;
					end
				end
				coinGamePkg::coinFall:
				begin
					if (dropTick)
					begin
						if (atBottom)
						begin
							landed <= 1'b1; // Position held for scoring
							state <= coinGamePkg::coinPick;
						end
						else
							coinY <= coinY + 1'b1; // One row down
					end
				end
				default: state <= coinGamePkg::coinPick;
			endcase
		end
	end

endmodule

// File: rtl/tickGen.sv
// ------------------------------------------------
// Tick generator, one-cycle pulse per interval
// ------------------------------------------------
`timescale 1ns/1ps

module tickGen
#(
	parameter int interval = 4
)
(
	input logic clk,
	input logic resetn,
	output logic tick
);

	logic [$clog2(interval)-1:0] count; // Phase within interval

	// Pulse on last count of each interval
	assign tick = (count == $clog2(interval)'(interval - 1));

	always_ff @(posedge clk)
	begin
		if (!resetn)
			count <= '0;
		else if (tick)
			count <= '0; // Wrap
		else
			count <= count + 1'b1;
	end

endmodule

// File: rtl/coinGamePkg.sv
// ------------------------------------------------
// Coin game shared definitions
// Screen geometry, tick rates, colours and states
// ------------------------------------------------
package coinGamePkg;

	localparam int screenWidth = 160; // Visible columns
	localparam int screenHeight = 120; // Visible rows
	localparam int paddleWidth = 4; // Paddle pixels
	localparam int paddleRow = 119; // Bottom row
	localparam int coinLastRow = 118; // Coin stops above paddle
	localparam int paddleStartX = 80; // Centre-ish
	localparam int paddleMaxX = 156; // screenWidth - paddleWidth

	// Scaled down for simulation
	localparam int dropInterval = 4; // Cycles per drop tick
	localparam int moveInterval = 8; // Cycles per move tick

	localparam int randomSeed = 27; // Random counter start

	localparam int xWidth = 8; // Column bits
	localparam int yWidth = 7; // Row bits

	typedef enum logic [2:0]
	{
		colourBlack = 3'b000,
		colourWhite = 3'b111
	} colourT;

	typedef enum logic
	{
		coinPick, // Waiting for a legal column
		coinFall // Dropping row by row
	} coinStateT;

	typedef enum logic [2:0]
	{
		writeIdle,
		writeCoinErase,
		writeCoinDraw,
		writePaddleErase,
		writePaddleDraw
	} writeStateT;

endpackage
